// File: hdl/aes_key_pkg.sv
// AES-128 key schedule definitions
`default_nettype none

package aes_key_pkg;

  parameter int WORD_W     = 32;
  parameter int KEY_WORDS  = 4;
  parameter int KEY_W      = WORD_W * KEY_WORDS;
  parameter int NUM_ROUNDS = 10;
  parameter int ROUND_W    = 4;

  parameter string SBOX_FILE = "sbox.hex";

  // bytes[3] is the most significant byte of the word
  typedef union packed {
    logic [WORD_W-1:0] word;
    logic [3:0][7:0]   bytes;
  } key_word_u;

  function automatic logic [7:0] rcon_f(input logic [ROUND_W-1:0] round);
    logic [7:0] rc;
    case (round)
      4'd1:    rc = 8'h01;
      4'd2:    rc = 8'h02;
      4'd3:    rc = 8'h04;
      4'd4:    rc = 8'h08;
      4'd5:    rc = 8'h10;
      4'd6:    rc = 8'h20;
      4'd7:    rc = 8'h40;
      4'd8:    rc = 8'h80;
      4'd9:    rc = 8'h1b;
      4'd10:   rc = 8'h36;
      default: rc = 8'h00;
    endcase
    return rc;
  endfunction

endpackage

`default_nettype wire

// File: hdl/sbox_rom.sv
// SubWord lookup table
`timescale 1ns/1ps
`default_nettype none

module sbox_rom import aes_key_pkg::*; (
  input  wire  [WORD_W-1:0] i_word,
  output logic [WORD_W-1:0] o_word
);

  logic [7:0] sbox_mem [0:255];
  key_word_u  in_u;
  key_word_u  out_u;

  initial begin
    $readmemh(SBOX_FILE, sbox_mem);
  end

  assign in_u = i_word;

  // one lookup per byte lane
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      out_u.bytes[i] = sbox_mem[in_u.bytes[i]];
    end
  end

  assign o_word = out_u.word;

endmodule

`default_nettype wire

// File: hdl/round_counter.sv
// Round index counter
`timescale 1ns/1ps
`default_nettype none

module round_counter import aes_key_pkg::*; (
  input  wire                clk,
  input  wire                areset,
  input  wire                i_clear,
  input  wire                i_step,
  output logic [ROUND_W-1:0] o_round,
  output logic               o_last_round
);

  // next step lands on the final round
  assign o_last_round = (o_round == ROUND_W'(NUM_ROUNDS - 1));

  always_ff @(posedge clk or negedge areset) begin
    if (!areset) begin
      o_round <= '0;
    end else if (i_clear) begin
      o_round <= '0;
    end else if (i_step) begin
      o_round <= o_round + 1'b1;
    end
  end

  // FSM must stop stepping once round 10 is reached
  assert_round_bound: assert property (
    @(posedge clk) disable iff (!areset)
    o_round <= ROUND_W'(NUM_ROUNDS)
  );

endmodule

`default_nettype wire

// File: hdl/key_round_fsm.sv
// Key expansion sequencer
`timescale 1ns/1ps
`default_nettype none

module key_round_fsm import aes_key_pkg::*; (
  input  wire  clk,
  input  wire  areset,
  input  wire  i_key_valid,
  input  wire  i_last_round,
  output logic o_key_ready,
  output logic o_cnt_clear,
  output logic o_cnt_step,
  output logic o_load,
  output logic o_advance,
  output logic o_wr_en,
  output logic o_expand_done
);

  typedef enum logic [1:0] {
    IDLE,
    EXPAND,
    DONE
  } state_t;

  state_t state;
  state_t state_nxt;
  logic   key_fire;

  assign o_key_ready = (state == IDLE);
  assign key_fire    = i_key_valid && o_key_ready;

  assign o_load      = key_fire;
  assign o_cnt_clear = key_fire;
  assign o_advance   = (state == EXPAND);
  assign o_cnt_step  = (state == EXPAND);
  // core holds round k while the counter shows k, so write it now
  assign o_wr_en     = (state == EXPAND) || (state == DONE);

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:    if (key_fire) state_nxt = EXPAND;
      EXPAND:  if (i_last_round) state_nxt = DONE;
      DONE:    state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge areset) begin
    if (!areset) begin
      state         <= IDLE;
      o_expand_done <= 1'b0;
    end else begin
      state         <= state_nxt;
      // round 10 lands in the store on the same edge
      o_expand_done <= (state == DONE);
    end
  end

  // busy for exactly eleven cycles after an accepted key, then ready again
  assert_busy_window: assert property (
    @(posedge clk) disable iff (!areset)
    key_fire |=> !o_key_ready [*NUM_ROUNDS+1] ##1 o_key_ready
  );

endmodule

`default_nettype wire

// File: hdl/key_schedule_core.sv
// Round key datapath
`timescale 1ns/1ps
`default_nettype none

module key_schedule_core import aes_key_pkg::*; (
  input  wire                clk,
  input  wire                areset,
  input  wire  [KEY_W-1:0]   i_key,
  input  wire                i_load,
  input  wire                i_advance,
  input  wire  [ROUND_W-1:0] i_round,
  output logic [KEY_W-1:0]   o_round_key
);

  // w_q[0] is the leftmost word of the key
  key_word_u        w_q   [KEY_WORDS];
  key_word_u        w_nxt [KEY_WORDS];
  key_word_u        rot_u;
  key_word_u        temp_u;
  logic [WORD_W-1:0] sub_word;
  logic [ROUND_W-1:0] next_round;

  assign next_round = i_round + 1'b1;

  // RotWord on the last word
  assign rot_u.bytes = {w_q[KEY_WORDS-1].bytes[2], w_q[KEY_WORDS-1].bytes[1],
                        w_q[KEY_WORDS-1].bytes[0], w_q[KEY_WORDS-1].bytes[3]};

  sbox_rom u_sbox (
    .i_word (rot_u.word),
    .o_word (sub_word)
  );

  always_comb begin
    temp_u          = sub_word;
    temp_u.bytes[3] = temp_u.bytes[3] ^ rcon_f(next_round);
    w_nxt[0].word   = w_q[0].word ^ temp_u.word;
    for (int i = 1; i < KEY_WORDS; i++) begin
      w_nxt[i].word = w_q[i].word ^ w_nxt[i-1].word;
    end
  end

  always_ff @(posedge clk or negedge areset) begin
    if (!areset) begin
      for (int i = 0; i < KEY_WORDS; i++) begin
        w_q[i] <= '0;
      end
    end else if (i_load) begin
      for (int i = 0; i < KEY_WORDS; i++) begin
        w_q[i] <= i_key[KEY_W-1-i*WORD_W -: WORD_W];
      end
    end else if (i_advance) begin
      for (int i = 0; i < KEY_WORDS; i++) begin
        w_q[i] <= w_nxt[i];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < KEY_WORDS; i++) begin
      o_round_key[KEY_W-1-i*WORD_W -: WORD_W] = w_q[i].word;
    end
  end

endmodule

`default_nettype wire

// File: hdl/round_key_store.sv
// Round key memory and read port
`timescale 1ns/1ps
`default_nettype none

module round_key_store import aes_key_pkg::*; (
  input  wire                clk,
  input  wire                areset,
  input  wire                i_clear,
  input  wire                i_wr_en,
  input  wire  [ROUND_W-1:0] i_wr_round,
  input  wire  [KEY_W-1:0]   i_wr_key,
  input  wire                i_rd_valid,
  input  wire  [ROUND_W-1:0] i_rd_round,
  output logic               o_rd_ready,
  output logic               o_rk_valid,
  output logic [KEY_W-1:0]   o_rk,
  input  wire                i_rk_ready
);

  logic [KEY_W-1:0]    rk_mem [0:NUM_ROUNDS];
  logic [NUM_ROUNDS:0] rk_valid;
  logic                rd_stored;
  logic                rd_fire;
  logic                rsp_drain;

  // requests beyond round 10 never become ready
  assign rd_stored  = (i_rd_round <= ROUND_W'(NUM_ROUNDS)) && rk_valid[i_rd_round];
  assign rsp_drain  = o_rk_valid && i_rk_ready;
  assign o_rd_ready = rd_stored && (!o_rk_valid || i_rk_ready);
  assign rd_fire    = i_rd_valid && o_rd_ready;

  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      rk_mem[i_wr_round] <= i_wr_key;
    end
  end

  // a new key wipes the flags before any of its rounds land
  always_ff @(posedge clk or negedge areset) begin
    if (!areset) begin
      rk_valid <= '0;
    end else if (i_clear) begin
      rk_valid <= '0;
    end else if (i_wr_en) begin
      rk_valid[i_wr_round] <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge areset) begin
    if (!areset) begin
      o_rk_valid <= 1'b0;
    end else if (rd_fire) begin
      o_rk_valid <= 1'b1;
    end else if (rsp_drain) begin
      o_rk_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      o_rk <= rk_mem[i_rd_round];
    end
  end

  assert_wr_round: assert property (
    @(posedge clk) disable iff (!areset)
    i_wr_en |-> (i_wr_round <= ROUND_W'(NUM_ROUNDS))
  );

  assert_rsp_hold: assert property (
    @(posedge clk) disable iff (!areset)
    (o_rk_valid && !i_rk_ready) |=> (o_rk_valid && $stable(o_rk))
  );

endmodule

`default_nettype wire

// File: hdl/aes_key_expand_top.sv
// AES-128 key expansion top
`timescale 1ns/1ps
`default_nettype none

module aes_key_expand_top import aes_key_pkg::*; (
  input  wire                clk,
  input  wire                areset,
  input  wire  [KEY_W-1:0]   i_key,
  input  wire                i_key_valid,
  output logic               o_key_ready,
  input  wire                i_rd_valid,
  input  wire  [ROUND_W-1:0] i_rd_round,
  output logic               o_rd_ready,
  output logic               o_rk_valid,
  output logic [KEY_W-1:0]   o_rk,
  input  wire                i_rk_ready,
  output logic               o_expand_done
);

  logic               cnt_clear;
  logic               cnt_step;
  logic               load;
  logic               advance;
  logic               wr_en;
  logic [ROUND_W-1:0] round;
  logic               last_round;
  logic [KEY_W-1:0]   round_key;

  key_round_fsm u_fsm (
    .clk           (clk),
    .areset        (areset),
    .i_key_valid   (i_key_valid),
    .i_last_round  (last_round),
    .o_key_ready   (o_key_ready),
    .o_cnt_clear   (cnt_clear),
    .o_cnt_step    (cnt_step),
    .o_load        (load),
    .o_advance     (advance),
    .o_wr_en       (wr_en),
    .o_expand_done (o_expand_done)
  );

  round_counter u_counter (
    .clk          (clk),
    .areset       (areset),
    .i_clear      (cnt_clear),
    .i_step       (cnt_step),
    .o_round      (round),
    .o_last_round (last_round)
  );

  key_schedule_core u_core (
    .clk         (clk),
    .areset      (areset),
    .i_key       (i_key),
    .i_load      (load),
    .i_advance   (advance),
    .i_round     (round),
    .o_round_key (round_key)
  );

  // counter value doubles as the write index
  round_key_store u_store (
    .clk        (clk),
    .areset     (areset),
    .i_clear    (load),
    .i_wr_en    (wr_en),
    .i_wr_round (round),
    .i_wr_key   (round_key),
    .i_rd_valid (i_rd_valid),
    .i_rd_round (i_rd_round),
    .o_rd_ready (o_rd_ready),
    .o_rk_valid (o_rk_valid),
    .o_rk       (o_rk),
    .i_rk_ready (i_rk_ready)
  );

endmodule

`default_nettype wire

// File: testbench/tb_key_model.svh
// AES-128 key model and LFSR
`ifndef TB_KEY_MODEL_SVH
`define TB_KEY_MODEL_SVH

logic [7:0]   model_sbox [0:255];
logic [127:0] model_rk   [0:10];
logic [31:0]  lfsr_state;

// galois form, taps 32 30 26 25
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  logic [31:0] n;
  n = s >> 1;
  if (s[0]) begin
    n = n ^ 32'ha3000000;
  end
  return n;
endfunction

// one lfsr step per bit taken
function automatic logic [127:0] rand_bits(input int n);
  logic [127:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_step(lfsr_state);
    r = {r[126:0], lfsr_state[0]};
  end
  return r;
endfunction

// multiply by x in GF(2^8), gives the next rcon
function automatic logic [7:0] xtime(input logic [7:0] b);
  logic [7:0] r;
  r = {b[6:0], 1'b0};
  if (b[7]) begin
    r = r ^ 8'h1b;
  end
  return r;
endfunction

function automatic logic [31:0] sub_word(input logic [31:0] w);
  return {model_sbox[w[31:24]], model_sbox[w[23:16]],
          model_sbox[w[15:8]], model_sbox[w[7:0]]};
endfunction

// FIPS-197 word expansion, 44 words
function automatic void expand_model(input logic [127:0] key);
  logic [31:0] w [0:43];
  logic [31:0] t;
  logic [7:0]  rc;
  rc = 8'h01;
  for (int i = 0; i < 4; i++) begin
    w[i] = key[127-32*i -: 32];
  end
  for (int i = 4; i < 44; i++) begin
    t = w[i-1];
    if (i % 4 == 0) begin
      t  = sub_word({t[23:0], t[31:24]}) ^ {rc, 24'h000000};
      rc = xtime(rc);
    end
    w[i] = w[i-4] ^ t;
  end
  for (int r = 0; r <= 10; r++) begin
    model_rk[r] = {w[4*r], w[4*r+1], w[4*r+2], w[4*r+3]};
  end
endfunction

`endif

// File: testbench/tb_aes_key_expand.sv
// AES-128 key expansion testbench
`timescale 1ns/1ps
`default_nettype none

module tb_aes_key_expand import aes_key_pkg::*;;

  localparam int     CLK_PERIOD      = 40;
  localparam int     DRIVE_DLY       = 2;
  localparam int     RESET_CYCLES    = 5;
  localparam int     NUM_RANDOM_KEYS = 20;
  localparam int     NUM_KEYS        = NUM_RANDOM_KEYS + 1;
  localparam int     KEY_BUDGET      = 200;
  localparam int     KEY_WAIT_MAX    = 20;
  localparam int     READ_CYCLES_MAX = 150;
  localparam longint WATCHDOG_NS     = (RESET_CYCLES + NUM_KEYS * KEY_BUDGET) * CLK_PERIOD;
  localparam logic [127:0] KAT_KEY   = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam logic [127:0] KAT_R10   = 128'hd014f9a8c9ee2589e13f0cc8b6630ca6;

  logic               clk;
  logic               areset;
  logic [KEY_W-1:0]   i_key;
  logic               i_key_valid;
  logic               o_key_ready;
  logic               i_rd_valid;
  logic [ROUND_W-1:0] i_rd_round;
  logic               o_rd_ready;
  logic               o_rk_valid;
  logic [KEY_W-1:0]   o_rk;
  logic               i_rk_ready;
  logic               o_expand_done;
  logic [127:0]       got_rk [0:10];

  `include "tb_key_model.svh"

  aes_key_expand_top UUT (
    .clk           (clk),
    .areset        (areset),
    .i_key         (i_key),
    .i_key_valid   (i_key_valid),
    .o_key_ready   (o_key_ready),
    .i_rd_valid    (i_rd_valid),
    .i_rd_round    (i_rd_round),
    .o_rd_ready    (o_rd_ready),
    .o_rk_valid    (o_rk_valid),
    .o_rk          (o_rk),
    .i_rk_ready    (i_rk_ready),
    .o_expand_done (o_expand_done)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                             input string what);
    if (actual !== expected) begin
      report_failure($sformatf("Error at %0t ns: %s, got %h, expected %h",
                               $time, what, actual, expected));
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  // hold the key until the handshake completes
  task automatic load_key(input logic [127:0] key);
    logic accepted;
    int   waited;
    accepted    = 1'b0;
    waited      = 0;
    i_key       = key;
    i_key_valid = 1'b1;
    while (!accepted && waited < KEY_WAIT_MAX) begin
      @(negedge clk);
      accepted = o_key_ready;
      waited++;
      next_cycle();
    end
    if (!accepted) begin
      report_failure("key handshake stalled, o_key_ready never went high");
    end
    i_key_valid = 1'b0;
    i_key       = rand_bits(128);
  endtask

  // load one key, then read all eleven rounds in random order
  task automatic run_key(input logic [127:0] key, input logic backpressure);
    logic [3:0]   order [0:10];
    logic [127:0] exp_q [$];
    int           round_q [$];
    logic [3:0]   tmp;
    int           j;
    int           next_idx;
    int           cyc;
    int           done_count;
    logic         stalled;
    logic         exp_ready;
    logic [127:0] held_rk;
    expand_model(key);
    for (int i = 0; i <= NUM_ROUNDS; i++) begin
      order[i] = 4'(i);
    end
    for (int i = NUM_ROUNDS; i > 0; i--) begin
      j        = int'(rand_bits(8)) % (i + 1);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    next_idx   = 0;
    cyc        = 0;
    done_count = 0;
    stalled    = 1'b0;
    held_rk    = '0;
    load_key(key);
    // cyc counts edges since the accept edge
    while (next_idx <= NUM_ROUNDS || exp_q.size() != 0 || cyc <= NUM_ROUNDS + 1) begin
      if (cyc > READ_CYCLES_MAX) begin
        report_failure("read port stalled, not every round key came back");
      end
      if (next_idx <= NUM_ROUNDS) begin
        i_rd_valid = 1'b1;
        i_rd_round = order[next_idx];
      end else begin
        i_rd_valid = 1'b0;
        i_rd_round = 4'(rand_bits(4));
      end
      if (backpressure) begin
        i_rk_ready = (rand_bits(1) != 0);
      end else begin
        i_rk_ready = 1'b1;
      end
      @(negedge clk);
      check_value(o_key_ready, cyc >= NUM_ROUNDS + 1, "o_key_ready during expansion");
      check_value(o_expand_done, cyc == NUM_ROUNDS + 1, "o_expand_done timing");
      if (o_expand_done) begin
        done_count++;
      end
      check_value(o_rk_valid, exp_q.size() != 0, "o_rk_valid");
      if (stalled) begin
        check_value(o_rk, held_rk, "o_rk while response is stalled");
      end
      // round r lands in the store at edge r+1
      exp_ready = (i_rd_round <= NUM_ROUNDS) && (cyc > int'(i_rd_round))
                  && (exp_q.size() == 0 || i_rk_ready);
      check_value(o_rd_ready, exp_ready, $sformatf("o_rd_ready for round %0d", i_rd_round));
      stalled = o_rk_valid && !i_rk_ready;
      held_rk = o_rk;
      if (o_rk_valid && i_rk_ready) begin
        check_value(o_rk, exp_q[0], $sformatf("round %0d key readback", round_q[0]));
        got_rk[round_q[0]] = o_rk;
        void'(exp_q.pop_front());
        void'(round_q.pop_front());
      end
      if (i_rd_valid && o_rd_ready) begin
        exp_q.push_back(model_rk[i_rd_round]);
        round_q.push_back(int'(i_rd_round));
        next_idx++;
      end
      next_cycle();
      cyc++;
    end
    check_value(done_count, 1, "o_expand_done pulses for one key");
  endtask

  initial begin
    #(WATCHDOG_NS);
    report_failure("watchdog expired, the tests did not finish in time");
  end

  initial begin
    lfsr_state  = 32'd7;
    areset      = 1'b0;
    i_key       = '0;
    i_key_valid = 1'b0;
    i_rd_valid  = 1'b0;
    i_rd_round  = '0;
    i_rk_ready  = 1'b0;
    $readmemh(SBOX_FILE, model_sbox);
    if (model_sbox[8'h00] !== 8'h63 || model_sbox[8'hff] !== 8'h16) begin
      report_failure("sbox data file could not be read by the testbench");
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    areset = 1'b1;
    @(negedge clk);
    check_value(o_key_ready, 1'b1, "o_key_ready after reset");
    check_value(o_rd_ready, 1'b0, "o_rd_ready after reset");
    check_value(o_rk_valid, 1'b0, "o_rk_valid after reset");
    check_value(o_expand_done, 1'b0, "o_expand_done after reset");
    next_cycle();

    // FIPS-197 known answer
    run_key(KAT_KEY, 1'b0);
    check_value(model_rk[10], KAT_R10, "model round 10 of the FIPS-197 key");
    check_value(got_rk[10], KAT_R10, "round 10 of the FIPS-197 key");

    // each random key is also a reload over the previous one
    for (int k = 0; k < NUM_RANDOM_KEYS; k++) begin
      run_key(rand_bits(128), 1'b1);
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: sbox.hex
// aes sbox, 16 bytes per row, row n holds entries 16*n to 16*n+15
63 7c 77 7b f2 6b 6f c5 30 01 67 2b fe d7 ab 76
ca 82 c9 7d fa 59 47 f0 ad d4 a2 af 9c a4 72 c0
b7 fd 93 26 36 3f f7 cc 34 a5 e5 f1 71 d8 31 15
04 c7 23 c3 18 96 05 9a 07 12 80 e2 eb 27 b2 75
09 83 2c 1a 1b 6e 5a a0 52 3b d6 b3 29 e3 2f 84
53 d1 00 ed 20 fc b1 5b 6a cb be 39 4a 4c 58 cf
d0 ef aa fb 43 4d 33 85 45 f9 02 7f 50 3c 9f a8
51 a3 40 8f 92 9d 38 f5 bc b6 da 21 10 ff f3 d2
cd 0c 13 ec 5f 97 44 17 c4 a7 7e 3d 64 5d 19 73
60 81 4f dc 22 2a 90 88 46 ee b8 14 de 5e 0b db
e0 32 3a 0a 49 06 24 5c c2 d3 ac 62 91 95 e4 79
e7 c8 37 6d 8d d5 4e a9 6c 56 f4 ea 65 7a ae 08
ba 78 25 2e 1c a6 b4 c6 e8 dd 74 1f 4b bd 8b 8a
70 3e b5 66 48 03 f6 0e 61 35 57 b9 86 c1 1d 9e
e1 f8 98 11 69 d9 8e 94 9b 1e 87 e9 ce 55 28 df
8c a1 89 0d bf e6 42 68 41 99 2d 0f b0 54 bb 16

// File: src.f
+incdir+testbench
hdl/aes_key_pkg.sv
hdl/sbox_rom.sv
hdl/round_counter.sv
hdl/key_round_fsm.sv
hdl/key_schedule_core.sv
hdl/round_key_store.sv
hdl/aes_key_expand_top.sv
testbench/tb_aes_key_expand.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_aes_key_expand -o tb_sim \
  && ./obj_dir/tb_sim | tee sim.log \
  && grep -q "TEST RESULT: PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
